// ==== src/vga_pkg.sv ====
package vga_pkg;

    // Width of the horizontal and vertical counters
    localparam int COUNT_WIDTH = 11;

    // Visible area of the 800x600 mode
    localparam logic [COUNT_WIDTH-1:0] HOR_PIXELS = 11'd800;
    localparam logic [COUNT_WIDTH-1:0] VER_PIXELS = 11'd600;

    // Full line and frame lengths including blanking
    localparam logic [COUNT_WIDTH-1:0] HOR_TOTAL = 11'd1056;
    localparam logic [COUNT_WIDTH-1:0] VER_TOTAL = 11'd628;

    // Horizontal sync pulse with exclusive stop
    localparam logic [COUNT_WIDTH-1:0] HOR_SYNC_START = 11'd840;
    localparam logic [COUNT_WIDTH-1:0] HOR_SYNC_STOP  = 11'd968;

    // Vertical sync pulse with exclusive stop
    localparam logic [COUNT_WIDTH-1:0] VER_SYNC_START = 11'd601;
    localparam logic [COUNT_WIDTH-1:0] VER_SYNC_STOP  = 11'd605;

    // Output colour while blanking
    localparam logic [11:0] BLANK_COLOR = 12'h888;

    // Screen fill once the game has started
    localparam logic [11:0] GAME_BACKGROUND = 12'h222;

    // Outermost visible rows and columns
    localparam logic [11:0] BORDER_COLOR = 12'hfff;

endpackage

// ==== src/vga_timing.sv ====
`timescale 1ns/1ps

module vga_timing (
    input  logic                            clk,
    input  logic                            rst,
    output logic [vga_pkg::COUNT_WIDTH-1:0] hcount,
    output logic [vga_pkg::COUNT_WIDTH-1:0] vcount,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            hblnk,
    output logic                            vblnk
);

    logic [vga_pkg::COUNT_WIDTH-1:0] hcount_nxt;
    logic [vga_pkg::COUNT_WIDTH-1:0] vcount_nxt;
    logic                            hsync_nxt;
    logic                            vsync_nxt;
    logic                            hblnk_nxt;
    logic                            vblnk_nxt;

    // Vertical counter steps on the horizontal wrap
    always_comb begin
        if (hcount == vga_pkg::HOR_TOTAL - 1'b1) begin
            hcount_nxt = '0;
            if (vcount == vga_pkg::VER_TOTAL - 1'b1) begin
                vcount_nxt = '0;
            end else begin
                vcount_nxt = vcount + 1'b1;
            end
        end else begin
            hcount_nxt = hcount + 1'b1;
            vcount_nxt = vcount;
        end
    end

    // Sync and blank are decoded from the next counts so that
    // the registered group describes one and the same pixel
    always_comb begin
        hblnk_nxt = (hcount_nxt >= vga_pkg::HOR_PIXELS);
        vblnk_nxt = (vcount_nxt >= vga_pkg::VER_PIXELS);
        hsync_nxt = (hcount_nxt >= vga_pkg::HOR_SYNC_START) &&
                    (hcount_nxt <  vga_pkg::HOR_SYNC_STOP);
        vsync_nxt = (vcount_nxt >= vga_pkg::VER_SYNC_START) &&
                    (vcount_nxt <  vga_pkg::VER_SYNC_STOP);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
        end else begin
            hcount <= hcount_nxt;
            vcount <= vcount_nxt;
            hsync  <= hsync_nxt;
            vsync  <= vsync_nxt;
            hblnk  <= hblnk_nxt;
            vblnk  <= vblnk_nxt;
        end
    end

endmodule

// ==== src/draw_bg.sv ====
`timescale 1ns/1ps

module draw_bg (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [vga_pkg::COUNT_WIDTH-1:0] in_hcount,
    input  logic [vga_pkg::COUNT_WIDTH-1:0] in_vcount,
    input  logic                            in_hsync,
    input  logic                            in_vsync,
    input  logic                            in_hblnk,
    input  logic                            in_vblnk,
    output logic [vga_pkg::COUNT_WIDTH-1:0] hcount,
    output logic [vga_pkg::COUNT_WIDTH-1:0] vcount,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            hblnk,
    output logic                            vblnk,
    output logic [11:0]                     rgb
);

    logic [11:0] rgb_nxt;
    logic        on_border;

    // First and last visible row or column
    assign on_border = (in_vcount == '0) ||
                       (in_vcount == vga_pkg::VER_PIXELS - 1'b1) ||
                       (in_hcount == '0) ||
                       (in_hcount == vga_pkg::HOR_PIXELS - 1'b1);

    always_comb begin
        if (in_hblnk || in_vblnk) begin
            rgb_nxt = vga_pkg::BLANK_COLOR;
        end else if (on_border) begin
            rgb_nxt = vga_pkg::BORDER_COLOR;
        end else begin
            rgb_nxt = 12'h000;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount <= '0;
            vcount <= '0;
            hsync  <= 1'b0;
            vsync  <= 1'b0;
            hblnk  <= 1'b0;
            vblnk  <= 1'b0;
            rgb    <= '0;
        end else begin
            hcount <= in_hcount;
            vcount <= in_vcount;
            hsync  <= in_hsync;
            vsync  <= in_vsync;
            hblnk  <= in_hblnk;
            vblnk  <= in_vblnk;
            rgb    <= rgb_nxt;
        end
    end

endmodule

// ==== src/delay.sv ====
`timescale 1ns/1ps

module delay #(
    parameter int WIDTH   = 1,
    parameter int CLK_DEL = 1
) (
    input  logic             clk,
    input  logic             rst,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout
);

    // stage[0] takes din, the last stage drives dout
    logic [WIDTH-1:0] stage [CLK_DEL];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < CLK_DEL; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= din;
            for (int i = 1; i < CLK_DEL; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign dout = stage[CLK_DEL-1];

endmodule

// ==== src/menu_rom.sv ====
`timescale 1ns/1ps

module menu_rom #(
    parameter int ROM_ADDR_WIDTH = 14
) (
    input  logic                      clk,
    input  logic [ROM_ADDR_WIDTH-1:0] addr,
    output logic [11:0]               rgb
);

    localparam int HALF_WIDTH = ROM_ADDR_WIDTH / 2;
    localparam int DEPTH      = 2 ** ROM_ADDR_WIDTH;

    logic [11:0] mem [DEPTH];

    // Row half sits in the upper address bits, column half in the lower
    // Each colour nibble comes from the top four bits of a half
    function automatic logic [11:0] pattern_word(input logic [ROM_ADDR_WIDTH-1:0] a);
        logic [HALF_WIDTH-1:0] row;
        logic [HALF_WIDTH-1:0] col;
        logic [3:0]            row_hi;
        logic [3:0]            col_hi;
        row    = a[ROM_ADDR_WIDTH-1 -: HALF_WIDTH];
        col    = a[HALF_WIDTH-1:0];
        row_hi = row[HALF_WIDTH-1 -: 4];
        col_hi = col[HALF_WIDTH-1 -: 4];
        return {row_hi, col_hi, row_hi ^ col_hi};
    endfunction

    // Image contents are fixed at elaboration
    initial begin
        for (int i = 0; i < DEPTH; i++) begin
            mem[i] = pattern_word(ROM_ADDR_WIDTH'(i));
        end
    end

    // One cycle read latency
    always_ff @(posedge clk) begin
        rgb <= mem[addr];
    end

endmodule

// ==== src/draw_menu.sv ====
`timescale 1ns/1ps

module draw_menu #(
    parameter int ROM_ADDR_WIDTH = 14
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_game,
    input  logic [11:0]                     rgb_pixel,
    output logic [ROM_ADDR_WIDTH-1:0]       pixel_addr,
    input  logic [vga_pkg::COUNT_WIDTH-1:0] in_hcount,
    input  logic [vga_pkg::COUNT_WIDTH-1:0] in_vcount,
    input  logic                            in_hsync,
    input  logic                            in_vsync,
    input  logic                            in_hblnk,
    input  logic                            in_vblnk,
    input  logic [11:0]                     in_rgb,
    output logic [vga_pkg::COUNT_WIDTH-1:0] hcount,
    output logic [vga_pkg::COUNT_WIDTH-1:0] vcount,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            hblnk,
    output logic                            vblnk,
    output logic [11:0]                     rgb
);

    localparam int HALF_WIDTH = ROM_ADDR_WIDTH / 2;
    localparam int DEL_WIDTH  = 2 * vga_pkg::COUNT_WIDTH + 4 + 12;

    logic [vga_pkg::COUNT_WIDTH-1:0] hcount_buf;
    logic [vga_pkg::COUNT_WIDTH-1:0] vcount_buf;
    logic                            hsync_buf;
    logic                            vsync_buf;
    logic                            hblnk_buf;
    logic                            vblnk_buf;
    logic [11:0]                     rgb_buf;
    logic [11:0]                     rgb_nxt;
    logic                            visible;

    // Two cycles covers the address register and the ROM read
    delay #(
        .WIDTH   (DEL_WIDTH),
        .CLK_DEL (2)
    ) u_delay (
        .clk  (clk),
        .rst  (rst),
        .din  ({in_hcount, in_hsync, in_hblnk, in_vcount, in_vsync, in_vblnk, in_rgb}),
        .dout ({hcount_buf, hsync_buf, hblnk_buf, vcount_buf, vsync_buf, vblnk_buf, rgb_buf})
    );

    assign visible = (hcount_buf < vga_pkg::HOR_PIXELS) && (vcount_buf < vga_pkg::VER_PIXELS);

    always_comb begin
        if (hblnk_buf || vblnk_buf) begin
            rgb_nxt = vga_pkg::BLANK_COLOR;
        end else if (start_game) begin
            rgb_nxt = vga_pkg::GAME_BACKGROUND;
        end else if (visible) begin
            rgb_nxt = rgb_pixel;
        end else begin
            rgb_nxt = rgb_buf;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hcount     <= '0;
            vcount     <= '0;
            hsync      <= 1'b0;
            vsync      <= 1'b0;
            hblnk      <= 1'b0;
            vblnk      <= 1'b0;
            rgb        <= '0;
            pixel_addr <= '0;
        end else begin
            hcount     <= hcount_buf;
            vcount     <= vcount_buf;
            hsync      <= hsync_buf;
            vsync      <= vsync_buf;
            hblnk      <= hblnk_buf;
            vblnk      <= vblnk_buf;
            rgb        <= rgb_nxt;
            // Scale by eight by dropping the three low bits of each count
            pixel_addr <= {in_vcount[HALF_WIDTH+2:3], in_hcount[HALF_WIDTH+2:3]};
        end
    end

endmodule

// ==== src/vga_top.sv ====
`timescale 1ns/1ps

module vga_top (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            start_game,
    output logic [vga_pkg::COUNT_WIDTH-1:0] hcount,
    output logic [vga_pkg::COUNT_WIDTH-1:0] vcount,
    output logic                            hsync,
    output logic                            vsync,
    output logic                            hblnk,
    output logic                            vblnk,
    output logic [11:0]                     rgb
);

    // 128x128 image with seven bits per half
    localparam int ROM_ADDR_WIDTH = 14;

    // Timing generator to background
    logic [vga_pkg::COUNT_WIDTH-1:0] tim_hcount;
    logic [vga_pkg::COUNT_WIDTH-1:0] tim_vcount;
    logic                            tim_hsync;
    logic                            tim_vsync;
    logic                            tim_hblnk;
    logic                            tim_vblnk;

    // Background to menu
    logic [vga_pkg::COUNT_WIDTH-1:0] bg_hcount;
    logic [vga_pkg::COUNT_WIDTH-1:0] bg_vcount;
    logic                            bg_hsync;
    logic                            bg_vsync;
    logic                            bg_hblnk;
    logic                            bg_vblnk;
    logic [11:0]                     bg_rgb;

    logic [ROM_ADDR_WIDTH-1:0]       pixel_addr;
    logic [11:0]                     rgb_pixel;

    vga_timing u_vga_timing (
        .clk    (clk),
        .rst    (rst),
        .hcount (tim_hcount),
        .vcount (tim_vcount),
        .hsync  (tim_hsync),
        .vsync  (tim_vsync),
        .hblnk  (tim_hblnk),
        .vblnk  (tim_vblnk)
    );

    draw_bg u_draw_bg (
        .clk       (clk),
        .rst       (rst),
        .in_hcount (tim_hcount),
        .in_vcount (tim_vcount),
        .in_hsync  (tim_hsync),
        .in_vsync  (tim_vsync),
        .in_hblnk  (tim_hblnk),
        .in_vblnk  (tim_vblnk),
        .hcount    (bg_hcount),
        .vcount    (bg_vcount),
        .hsync     (bg_hsync),
        .vsync     (bg_vsync),
        .hblnk     (bg_hblnk),
        .vblnk     (bg_vblnk),
        .rgb       (bg_rgb)
    );

    draw_menu #(
        .ROM_ADDR_WIDTH (ROM_ADDR_WIDTH)
    ) u_draw_menu (
        .clk        (clk),
        .rst        (rst),
        .start_game (start_game),
        .rgb_pixel  (rgb_pixel),
        .pixel_addr (pixel_addr),
        .in_hcount  (bg_hcount),
        .in_vcount  (bg_vcount),
        .in_hsync   (bg_hsync),
        .in_vsync   (bg_vsync),
        .in_hblnk   (bg_hblnk),
        .in_vblnk   (bg_vblnk),
        .in_rgb     (bg_rgb),
        .hcount     (hcount),
        .vcount     (vcount),
        .hsync      (hsync),
        .vsync      (vsync),
        .hblnk      (hblnk),
        .vblnk      (vblnk),
        .rgb        (rgb)
    );

    menu_rom #(
        .ROM_ADDR_WIDTH (ROM_ADDR_WIDTH)
    ) u_menu_rom (
        .clk  (clk),
        .addr (pixel_addr),
        .rgb  (rgb_pixel)
    );

endmodule

// ==== testbench/vga_top_props.sv ====
`timescale 1ns/1ps

module vga_top_props (
    input logic                            clk,
    input logic                            rst,
    input logic                            start_game,
    input logic [vga_pkg::COUNT_WIDTH-1:0] hcount,
    input logic [vga_pkg::COUNT_WIDTH-1:0] vcount,
    input logic                            hsync,
    input logic                            vsync,
    input logic                            hblnk,
    input logic                            vblnk,
    input logic [11:0]                     rgb,
    input logic [vga_pkg::COUNT_WIDTH-1:0] bg_hcount,
    input logic [vga_pkg::COUNT_WIDTH-1:0] bg_vcount,
    input logic [11:0]                     bg_rgb
);

    localparam int CW = vga_pkg::COUNT_WIDTH;

    int count_fails  = 0;
    int sync_fails   = 0;
    int colour_fails = 0;
    int border_fails = 0;
    int reset_fails  = 0;

    logic [3:0]    settle_cnt;
    logic          settled;
    logic          prev_start;
    logic [CW-1:0] prev_hcount;
    logic [CW-1:0] prev_vcount;
    logic [CW-1:0] exp_hcount;
    logic [CW-1:0] exp_vcount;
    logic [3:0]    exp_flags;
    logic [11:0]   exp_rgb;
    logic [11:0]   exp_bg_rgb;

    // Image nibbles are the top four bits of each count divided by eight
    function automatic logic [11:0] menu_color(input logic [CW-1:0] h, input logic [CW-1:0] v);
        logic [3:0] rn;
        logic [3:0] cn;
        rn = 4'(v / 11'd64);
        cn = 4'(h / 11'd64);
        return {rn, cn, rn ^ cn};
    endfunction

    always_ff @(posedge clk) begin
        if (rst) begin
            settle_cnt  <= '0;
            prev_start  <= 1'b0;
            prev_hcount <= '0;
            prev_vcount <= '0;
        end else begin
            if (!settled) begin
                settle_cnt <= settle_cnt + 1'b1;
            end
            prev_start  <= start_game;
            prev_hcount <= hcount;
            prev_vcount <= vcount;
        end
    end

    // Pipeline still shows reset values for a few cycles
    assign settled = (settle_cnt == 4'd8);

    // Next raster position after the previous one
    assign exp_hcount = CW'((prev_hcount + 1) % vga_pkg::HOR_TOTAL);
    assign exp_vcount = (prev_hcount == vga_pkg::HOR_TOTAL - 1'b1) ?
                        CW'((prev_vcount + 1) % vga_pkg::VER_TOTAL) : prev_vcount;

    // Order is hsync, vsync, hblnk, vblnk
    assign exp_flags = {(hcount >= vga_pkg::HOR_SYNC_START) && (hcount < vga_pkg::HOR_SYNC_STOP),
                        (vcount >= vga_pkg::VER_SYNC_START) && (vcount < vga_pkg::VER_SYNC_STOP),
                        hcount >= vga_pkg::HOR_PIXELS,
                        vcount >= vga_pkg::VER_PIXELS};

    always_comb begin
        if (exp_flags[1] || exp_flags[0]) begin
            exp_rgb = vga_pkg::BLANK_COLOR;
        end else if (prev_start) begin
            exp_rgb = vga_pkg::GAME_BACKGROUND;
        end else begin
            exp_rgb = menu_color(hcount, vcount);
        end
    end

    // Border frame as painted by the background stage
    always_comb begin
        if (bg_hcount >= vga_pkg::HOR_PIXELS || bg_vcount >= vga_pkg::VER_PIXELS) begin
            exp_bg_rgb = vga_pkg::BLANK_COLOR;
        end else if (bg_hcount == '0 || bg_vcount == '0 ||
                     bg_hcount == vga_pkg::HOR_PIXELS - 1'b1 ||
                     bg_vcount == vga_pkg::VER_PIXELS - 1'b1) begin
            exp_bg_rgb = vga_pkg::BORDER_COLOR;
        end else begin
            exp_bg_rgb = 12'h000;
        end
    end

    assert property (@(posedge clk) disable iff (rst || !settled)
        {hcount, vcount} == {exp_hcount, exp_vcount})
        else begin
            count_fails++;
            $error("Fail hcount,vcount expected %h,%h got %h,%h", $sampled(exp_hcount),
                   $sampled(exp_vcount), $sampled(hcount), $sampled(vcount));
        end

    assert property (@(posedge clk) disable iff (rst)
        {hsync, vsync, hblnk, vblnk} == exp_flags)
        else begin
            sync_fails++;
            $error("Fail hsync,vsync,hblnk,vblnk expected %h got %h", $sampled(exp_flags),
                   $sampled({hsync, vsync, hblnk, vblnk}));
        end

    assert property (@(posedge clk) disable iff (rst) rgb == exp_rgb)
        else begin
            colour_fails++;
            $error("Fail rgb expected %h got %h", $sampled(exp_rgb), $sampled(rgb));
        end

    assert property (@(posedge clk) disable iff (rst || !settled) bg_rgb == exp_bg_rgb)
        else begin
            border_fails++;
            $error("Fail bg_rgb expected %h got %h", $sampled(exp_bg_rgb), $sampled(bg_rgb));
        end

    // All outputs read zero in the first cycle out of reset
    assert property (@(posedge clk)
        $fell(rst) |-> ({hcount, vcount, hsync, vsync, hblnk, vblnk, rgb} == '0))
        else begin
            reset_fails++;
            $error("Fail {hcount,vcount,hsync,vsync,hblnk,vblnk,rgb} expected %h got %h",
                   38'h0, $sampled({hcount, vcount, hsync, vsync, hblnk, vblnk, rgb}));
        end

endmodule

bind vga_top vga_top_props props_inst (.*);

// ==== testbench/vga_top_tb.sv ====
`timescale 1ns/1ps

module vga_top_tb;

    localparam int FRAME_CYCLES = int'(vga_pkg::HOR_TOTAL) * int'(vga_pkg::VER_TOTAL);
    localparam int LINE_CYCLES  = int'(vga_pkg::HOR_TOTAL);
    localparam int CYCLE_LIMIT  = 3 * FRAME_CYCLES + 1000;

    logic                            clk;
    logic                            rst;
    logic                            start_game;
    logic [vga_pkg::COUNT_WIDTH-1:0] hcount;
    logic [vga_pkg::COUNT_WIDTH-1:0] vcount;
    logic                            hsync;
    logic                            vsync;
    logic                            hblnk;
    logic                            vblnk;
    logic [11:0]                     rgb;
    logic [31:0]                     lfsr;
    int                              cycle_count;
    int                              total_errors;

    vga_top vga_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Right shifting Galois LFSR with polynomial x^32 + x^31 + x^29 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 32'hD000_0001;
        end
        return state >> 1;
    endfunction

    // One LFSR step for every bit taken
    task automatic take_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsr_step(lfsr);
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        int level;
        int run;
        int left;
        int hold;
        rst        = 1'b1;
        start_game = 1'b0;
        lfsr       = 32'hedec444a;
        repeat (2) @(negedge clk);
        rst = 1'b0;

        // First frame shows the menu image only
        repeat (FRAME_CYCLES) @(negedge clk);

        // Second frame toggles start_game in runs of 1 to 64 lines
        left = FRAME_CYCLES;
        while (left > 0) begin
            take_bits(1, level);
            take_bits(6, run);
            hold = (run + 1) * LINE_CYCLES;
            if (hold > left) begin
                hold = left;
            end
            start_game = level[0];
            repeat (hold) @(negedge clk);
            left = left - hold;
        end

        // Third frame is all game background
        start_game = 1'b1;
        repeat (FRAME_CYCLES) @(negedge clk);
        repeat (8) @(negedge clk);

        total_errors = vga_top_inst.props_inst.count_fails +
                       vga_top_inst.props_inst.sync_fails +
                       vga_top_inst.props_inst.colour_fails +
                       vga_top_inst.props_inst.border_fails +
                       vga_top_inst.props_inst.reset_fails;
        $display("Errors: counters %0d, sync and blank %0d, rgb %0d, border %0d, reset %0d",
                 vga_top_inst.props_inst.count_fails, vga_top_inst.props_inst.sync_fails,
                 vga_top_inst.props_inst.colour_fails, vga_top_inst.props_inst.border_fails,
                 vga_top_inst.props_inst.reset_fails);
        if (total_errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/vga_pkg.sv
src/vga_timing.sv
src/draw_bg.sv
src/delay.sv
src/menu_rom.sv
src/draw_menu.sv
src/vga_top.sv
testbench/vga_top_props.sv
testbench/vga_top_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert --timing
TOP       = vga_top_tb
FILELIST  = sources.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUN_FLAGS = +verilator+error+limit+100000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
